//--- design/matrix_div_cfg.svh
// Width macros for the matrix divider datapath and index counters

`ifndef MATRIX_DIV_CFG_SVH
`define MATRIX_DIV_CFG_SVH

// Operand, quotient and remainder width
`define MATRIX_DIV_DATA_SIZE 16

// Row and column index width, 4 bits gives up to 15 by 15
`define MATRIX_DIV_CONTROL_SIZE 4

`endif

//--- design/matrix_div_pkg.sv
// Shared types for the matrix divider
// Operand and index words, controller state encodings

`default_nettype none

`include "matrix_div_cfg.svh"

package matrix_div_pkg;

  localparam int DATA_SIZE    = `MATRIX_DIV_DATA_SIZE;
  localparam int CONTROL_SIZE = `MATRIX_DIV_CONTROL_SIZE;

  // Unsigned operand word
  typedef logic [DATA_SIZE-1:0] data_t;
  // Sizes, loop indices, element counts
  typedef logic [CONTROL_SIZE-1:0] index_t;

  // Matrix controller, walks rows and columns
  typedef enum logic [1:0] {mat_idle, mat_input_row, mat_input_col, mat_wait_result} matrix_state_t;

  // Vector divider, one element at a time
  typedef enum logic [1:0] {vec_idle, vec_load, vec_divide, vec_emit} vector_state_t;

endpackage

`default_nettype wire

//--- design/vector_div_if.sv
// Handshake bundle between the matrix controller and the vector divider

`timescale 1ns/1ns
`default_nettype none

interface vector_div_if;
  import matrix_div_pkg::*;

  // Row control, from the controller
  logic   start;
  index_t size;

  // Operand A and its one-cycle enable
  data_t  data_a;
  logic   data_a_enable;

  // Operand B and its one-cycle enable
  data_t  data_b;
  logic   data_b_enable;

  // Element results back from the vector divider
  data_t  data_out;
  data_t  rest_out;
  logic   data_out_enable;
  // Pulses with the last element of the row
  logic   ready;

  modport ctrl (
    output start, size, data_a, data_a_enable, data_b, data_b_enable,
    input  data_out, rest_out, data_out_enable, ready
  );

  modport vec (
    input  start, size, data_a, data_a_enable, data_b, data_b_enable,
    output data_out, rest_out, data_out_enable, ready
  );

endinterface

`default_nettype wire

//--- design/integer_divider.sv
// Sequential restoring unsigned divider, one quotient bit per cycle

`timescale 1ns/1ns
`default_nettype none

module integer_divider (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  start,
  input  matrix_div_pkg::data_t dividend,
  input  matrix_div_pkg::data_t divisor,
  output logic                  done,
  output matrix_div_pkg::data_t quotient,
  output matrix_div_pkg::data_t remainder
);
  import matrix_div_pkg::*;

  localparam int CNT_W = $clog2(DATA_SIZE + 1);

  // Iteration state
  logic             busy;
  logic [CNT_W-1:0] count;
  logic             div_zero;
  // Partial remainder and the dividend bits shifting out as quotient bits shift in
  data_t            rem_r;
  data_t            quo_r;
  data_t            div_r;

  // Trial subtraction with the borrow in the top bit
  logic [DATA_SIZE:0] shifted;
  logic [DATA_SIZE:0] diff;

  assign shifted = {rem_r, quo_r[DATA_SIZE-1]};
  assign diff    = shifted - {1'b0, div_r};

  ////////////////////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy     <= 1'b0;
      count    <= '0;
      div_zero <= 1'b0;
      done     <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy     <= 1'b1;
        count    <= CNT_W'(DATA_SIZE);
        div_zero <= (divisor == '0);
      end else if (busy) begin
        if (count != '0) begin
          count <= count - 1'b1;
        end else begin
          // Extra result cycle keeps the latency at DATA_SIZE+1
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (start) begin
      rem_r <= '0;
      quo_r <= dividend;
      div_r <= divisor;
    end else if (busy && count != '0) begin
      // Restore on borrow, otherwise keep the difference
      if (diff[DATA_SIZE]) begin
        rem_r <= shifted[DATA_SIZE-1:0];
        quo_r <= {quo_r[DATA_SIZE-2:0], 1'b0};
      end else begin
        rem_r <= diff[DATA_SIZE-1:0];
        quo_r <= {quo_r[DATA_SIZE-2:0], 1'b1};
      end
    end
    if (busy && count == '0) begin
      // Zero divisor gives all ones and the dividend back
      // rem_r has shifted in every dividend bit by now
      quotient  <= div_zero ? '1 : quo_r;
      remainder <= rem_r;
    end
  end

endmodule

`default_nettype wire

//--- design/vector_integer_divider.sv
// Vector divider, runs one row of element pairs through the scalar divider

`timescale 1ns/1ns
`default_nettype none

module vector_integer_divider (
  input logic       CLK,
  input logic       RST,
  vector_div_if.vec bus
);
  import matrix_div_pkg::*;

  vector_state_t state;
  // Row length, latched at start
  index_t        size_r;
  index_t        count;

  // Captured operands
  data_t         a_r;
  data_t         b_r;
  logic          have_a;
  logic          have_b;

  // Scalar divider hookup
  logic          in_row;
  logic          div_start;
  logic          div_done;
  data_t         dividend;
  data_t         divisor;
  data_t         quotient;
  data_t         remainder;

  // Launch in the same cycle the second operand shows up
  assign in_row    = (state == vec_load) || (state == vec_idle && bus.start);
  assign div_start = in_row && (have_a || bus.data_a_enable) && (have_b || bus.data_b_enable);
  // Bypass for an operand arriving in the launch cycle
  assign dividend  = have_a ? a_r : bus.data_a;
  assign divisor   = have_b ? b_r : bus.data_b;

  integer_divider u_integer_divider (
    .CLK      (CLK),
    .RST      (RST),
    .start    (div_start),
    .dividend (dividend),
    .divisor  (divisor),
    .done     (div_done),
    .quotient (quotient),
    .remainder(remainder)
  );

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state               <= vec_idle;
      size_r              <= '0;
      count               <= '0;
      have_a              <= 1'b0;
      have_b              <= 1'b0;
      bus.data_out_enable <= 1'b0;
      bus.ready           <= 1'b0;
    end else begin
      bus.data_out_enable <= 1'b0;
      bus.ready           <= 1'b0;

      // Operands tracked independently of the state
      if (div_start) begin
        have_a <= 1'b0;
        have_b <= 1'b0;
      end else begin
        if (bus.data_a_enable) have_a <= 1'b1;
        if (bus.data_b_enable) have_b <= 1'b1;
      end

      case (state)
        vec_idle: begin
          if (bus.start) begin
            size_r <= bus.size;
            count  <= '0;
            state  <= div_start ? vec_divide : vec_load;
          end
        end
        vec_load: begin
          if (div_start) state <= vec_divide;
        end
        vec_divide: begin
          if (div_done) begin
            bus.data_out_enable <= 1'b1;
            // Last element of the row
            bus.ready           <= (count == index_t'(size_r - 1'b1));
            count               <= count + 1'b1;
            state               <= vec_emit;
          end
        end
        vec_emit: begin
          state <= bus.ready ? vec_idle : vec_load;
        end
        default: state <= vec_idle;
      endcase
    end
  end

  // Operand and result registers
  always_ff @(posedge CLK) begin
    if (bus.data_a_enable) a_r <= bus.data_a;
    if (bus.data_b_enable) b_r <= bus.data_b;
    if (div_done) begin
      bus.data_out <= quotient;
      bus.rest_out <= remainder;
    end
  end

endmodule

`default_nettype wire

//--- design/matrix_integer_divider.sv
// Matrix controller, walks rows and columns and feeds rows to the vector divider
// Registers the element, row-end and matrix-end strobes

`timescale 1ns/1ns
`default_nettype none

module matrix_integer_divider (
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   start,
  input  matrix_div_pkg::index_t size_i,
  input  matrix_div_pkg::index_t size_j,
  input  matrix_div_pkg::data_t  data_a,
  input  matrix_div_pkg::data_t  data_b,
  input  logic                   data_a_i_enable,
  input  logic                   data_a_j_enable,
  input  logic                   data_b_i_enable,
  input  logic                   data_b_j_enable,
  vector_div_if.ctrl             bus,
  output logic                   ready,
  output logic                   data_out_i_enable,
  output logic                   data_out_j_enable,
  output matrix_div_pkg::data_t  data_out,
  output matrix_div_pkg::data_t  rest_out
);
  import matrix_div_pkg::*;

  matrix_state_t state;

  // Sizes held for the whole matrix
  index_t        size_i_r;
  index_t        size_j_r;
  index_t        index_i;
  index_t        index_j;

  // Operands of the current pair already taken
  logic          got_a;
  logic          got_b;

  logic          acc_a;
  logic          acc_b;
  logic          pair_done;
  logic          last_row;

  // i-enables only in input_row, j-enables only in input_col
  assign acc_a = (state == mat_input_row && data_a_i_enable) ||
                 (state == mat_input_col && data_a_j_enable);
  assign acc_b = (state == mat_input_row && data_b_i_enable) ||
                 (state == mat_input_col && data_b_j_enable);

  assign pair_done = (got_a || acc_a) && (got_b || acc_b);
  assign last_row  = (index_i == index_t'(size_i_r - 1'b1));

  ////////////////////////////////////////////////////////////////////////////
  // FSM and strobes
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state             <= mat_idle;
      size_i_r          <= '0;
      size_j_r          <= '0;
      index_i           <= '0;
      index_j           <= '0;
      got_a             <= 1'b0;
      got_b             <= 1'b0;
      bus.start         <= 1'b0;
      bus.data_a_enable <= 1'b0;
      bus.data_b_enable <= 1'b0;
      ready             <= 1'b0;
      data_out_i_enable <= 1'b0;
      data_out_j_enable <= 1'b0;
      data_out          <= '0;
      rest_out          <= '0;
    end else begin
      bus.start         <= 1'b0;
      // Accepted operands go out one cycle later
      bus.data_a_enable <= acc_a;
      bus.data_b_enable <= acc_b;
      ready             <= 1'b0;
      data_out_i_enable <= 1'b0;
      data_out_j_enable <= 1'b0;

      case (state)
        mat_idle: begin
          if (start) begin
            size_i_r <= size_i;
            size_j_r <= size_j;
            index_i  <= '0;
            index_j  <= '0;
            got_a    <= 1'b0;
            got_b    <= 1'b0;
            state    <= mat_input_row;
          end
        end
        mat_input_row, mat_input_col: begin
          if (pair_done) begin
            got_a     <= 1'b0;
            got_b     <= 1'b0;
            // First pair of a row opens the row
            bus.start <= (index_j == '0);
            state     <= mat_wait_result;
          end else begin
            if (acc_a) got_a <= 1'b1;
            if (acc_b) got_b <= 1'b1;
          end
        end
        mat_wait_result: begin
          if (bus.data_out_enable) begin
            data_out          <= bus.data_out;
            rest_out          <= bus.rest_out;
            data_out_j_enable <= 1'b1;
            if (bus.ready && last_row) begin
              // Matrix end
              ready <= 1'b1;
              state <= mat_idle;
            end else if (bus.ready) begin
              // Row end, next row
              data_out_i_enable <= 1'b1;
              index_i           <= index_i + 1'b1;
              index_j           <= '0;
              state             <= mat_input_row;
            end else begin
              index_j <= index_j + 1'b1;
              state   <= mat_input_col;
            end
          end
        end
        default: state <= mat_idle;
      endcase
    end
  end

  // Forwarded operands and row length
  always_ff @(posedge CLK) begin
    if (acc_a) bus.data_a <= data_a;
    if (acc_b) bus.data_b <= data_b;
    if (pair_done) bus.size <= size_j_r;
  end

endmodule

`default_nettype wire

//--- design/matrix_div_top.sv
// Matrix divider top level, controller and vector divider on one bus

`timescale 1ns/1ns
`default_nettype none

module matrix_div_top (
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   start,
  input  matrix_div_pkg::index_t size_i,
  input  matrix_div_pkg::index_t size_j,
  input  matrix_div_pkg::data_t  data_a,
  input  matrix_div_pkg::data_t  data_b,
  input  logic                   data_a_i_enable,
  input  logic                   data_a_j_enable,
  input  logic                   data_b_i_enable,
  input  logic                   data_b_j_enable,
  output logic                   ready,
  output matrix_div_pkg::data_t  data_out,
  output matrix_div_pkg::data_t  rest_out,
  output logic                   data_out_i_enable,
  output logic                   data_out_j_enable
);

  // Row handshake
  vector_div_if bus_if ();

  matrix_integer_divider u_matrix_divider (
    .CLK              (CLK),
    .RST              (RST),
    .start            (start),
    .size_i           (size_i),
    .size_j           (size_j),
    .data_a           (data_a),
    .data_b           (data_b),
    .data_a_i_enable  (data_a_i_enable),
    .data_a_j_enable  (data_a_j_enable),
    .data_b_i_enable  (data_b_i_enable),
    .data_b_j_enable  (data_b_j_enable),
    .bus              (bus_if.ctrl),
    .ready            (ready),
    .data_out_i_enable(data_out_i_enable),
    .data_out_j_enable(data_out_j_enable),
    .data_out         (data_out),
    .rest_out         (rest_out)
  );

  vector_integer_divider u_vector_divider (
    .CLK(CLK),
    .RST(RST),
    .bus(bus_if.vec)
  );

endmodule

`default_nettype wire

//--- test/matrix_div_properties.sv
// Strobe protocol assertions for the matrix controller, and their bind

`timescale 1ns/1ns
`default_nettype none

module matrix_div_properties (
  input logic                          CLK,
  input logic                          RST,
  input matrix_div_pkg::matrix_state_t state,
  input logic                          ready,
  input logic                          data_out_i_enable,
  input logic                          data_out_j_enable
);
  import matrix_div_pkg::*;

  // Count of failed assertions
  int error_count = 0;

  // Matrix end is a single pulse
  ready_single: assert property (@(posedge CLK) disable iff (RST) ready |=> !ready)
    else begin
      error_count = error_count + 1;
      $error("ready lasted more than one cycle");
    end

  // Matrix end and row end both ride on an element strobe
  ready_with_element: assert property (@(posedge CLK) disable iff (RST)
    ready |-> data_out_j_enable)
    else begin
      error_count = error_count + 1;
      $error("ready without data_out_j_enable");
    end

  row_end_with_element: assert property (@(posedge CLK) disable iff (RST)
    data_out_i_enable |-> data_out_j_enable)
    else begin
      error_count = error_count + 1;
      $error("data_out_i_enable without data_out_j_enable");
    end

  // Final row never flags a row end
  ready_not_row_end: assert property (@(posedge CLK) disable iff (RST)
    !(ready && data_out_i_enable))
    else begin
      error_count = error_count + 1;
      $error("ready and data_out_i_enable together");
    end

  // Nothing is emitted out of the idle state
  idle_quiet: assert property (@(posedge CLK) disable iff (RST)
    (state == mat_idle) |=> !(ready || data_out_i_enable || data_out_j_enable))
    else begin
      error_count = error_count + 1;
      $error("output strobe issued from the idle state");
    end

endmodule

bind matrix_integer_divider matrix_div_properties u_properties (
  .CLK              (CLK),
  .RST              (RST),
  .state            (state),
  .ready            (ready),
  .data_out_i_enable(data_out_i_enable),
  .data_out_j_enable(data_out_j_enable)
);

`default_nettype wire

//--- test/matrix_div_tb.sv
// Matrix divider testbench, LFSR operands against a reference quotient and remainder
// Checks element values, row-end and matrix-end strobes, strobe counts

`timescale 1ns/1ns
`default_nettype none

module matrix_div_tb;
  import matrix_div_pkg::*;

  // Cycles allowed for one element result
  localparam int TIMEOUT = 4 * DATA_SIZE + 20;

  logic   CLK;
  logic   RST;
  logic   start;
  index_t size_i;
  index_t size_j;
  data_t  data_a;
  data_t  data_b;
  logic   data_a_i_enable;
  logic   data_a_j_enable;
  logic   data_b_i_enable;
  logic   data_b_j_enable;
  logic   ready;
  data_t  data_out;
  data_t  rest_out;
  logic   data_out_i_enable;
  logic   data_out_j_enable;

  logic [15:0] lfsr;
  // Running strobe counts
  int          j_pulses = 0;
  int          ready_pulses = 0;

  matrix_div_top i_dut (
    .CLK              (CLK),
    .RST              (RST),
    .start            (start),
    .size_i           (size_i),
    .size_j           (size_j),
    .data_a           (data_a),
    .data_b           (data_b),
    .data_a_i_enable  (data_a_i_enable),
    .data_a_j_enable  (data_a_j_enable),
    .data_b_i_enable  (data_b_i_enable),
    .data_b_j_enable  (data_b_j_enable),
    .ready            (ready),
    .data_out         (data_out),
    .rest_out         (rest_out),
    .data_out_i_enable(data_out_i_enable),
    .data_out_j_enable(data_out_j_enable)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    if (data_out_j_enable === 1'b1) j_pulses <= j_pulses + 1;
    if (ready === 1'b1) ready_pulses <= ready_pulses + 1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus and reference helpers
  ////////////////////////////////////////////////////////////////////////////

  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per bit of the word
  task automatic random_word(output data_t w);
    int k;
    w = '0;
    for (k = 0; k < DATA_SIZE; k++) begin
      lfsr = lfsr_step(lfsr);
      w    = {w[DATA_SIZE-2:0], lfsr[0]};
    end
  endtask

  // Unsigned division, zero divisor gives all ones
  function automatic data_t expect_quotient(input data_t a, input data_t b);
    return (b == '0) ? '1 : data_t'(a / b);
  endfunction

  // Zero divisor hands the dividend back
  function automatic data_t expect_remainder(input data_t a, input data_t b);
    return (b == '0) ? a : data_t'(a % b);
  endfunction

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (act === exp) else
      stop_with_failure($sformatf("CHECK FAILED at %0t ns: %s expected 0x%0h, got 0x%0h",
                                  $time, name, exp, act));
  endtask

  // Mode 0: nonzero divisors, every third one above the dividend
  // Mode 1: zero divisor on every other element
  task automatic make_pair(input int mode, input int k, output data_t a, output data_t b);
    random_word(a);
    random_word(b);
    if (mode == 1) begin
      if (k % 2 == 0) b = '0;
    end else if (k % 3 == 2) begin
      a = a >> 1;
      b = a + (b >> 1) + 1'b1;
    end else if (b == '0) begin
      b = data_t'(1);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // One matrix, pair by pair, paced by data_out_j_enable
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_matrix(input int ni, input int nj, input int mode);
    data_t a;
    data_t b;
    int    i;
    int    j;
    int    k;
    int    waited;
    int    j_base;
    int    ready_base;
    j_base     = j_pulses;
    ready_base = ready_pulses;
    @(posedge CLK);
    start  <= 1'b1;
    size_i <= index_t'(ni);
    size_j <= index_t'(nj);
    @(posedge CLK);
    start  <= 1'b0;
    // Sizes must already be latched
    size_i <= '0;
    size_j <= '0;
    k = 0;
    for (i = 0; i < ni; i++) begin
      for (j = 0; j < nj; j++) begin
        make_pair(mode, k, a, b);
        @(posedge CLK);
        data_a          <= a;
        data_b          <= b;
        data_a_i_enable <= (j == 0);
        data_b_i_enable <= (j == 0);
        data_a_j_enable <= (j != 0);
        data_b_j_enable <= (j != 0);
        @(posedge CLK);
        data_a_i_enable <= 1'b0;
        data_b_i_enable <= 1'b0;
        data_a_j_enable <= 1'b0;
        data_b_j_enable <= 1'b0;
        waited = 0;
        while (data_out_j_enable !== 1'b1) begin
          if (waited == TIMEOUT)
            stop_with_failure($sformatf("Timeout: data_out_j_enable never came for row %0d column %0d",
                                        i, j));
          @(posedge CLK);
          waited++;
        end
        check_value("data_out", expect_quotient(a, b), data_out);
        check_value("rest_out", expect_remainder(a, b), rest_out);
        check_value("data_out_i_enable", (j == nj - 1) && (i != ni - 1), data_out_i_enable);
        check_value("ready", (j == nj - 1) && (i == ni - 1), ready);
        k++;
      end
    end
    // Let the counters settle, then look for stray strobes
    repeat (3) @(posedge CLK);
    check_value("data_out_j_enable count", ni * nj, j_pulses - j_base);
    check_value("ready count", 1, ready_pulses - ready_base);
  endtask

  initial begin
    RST             = 1'b1;
    start           = 1'b0;
    size_i          = '0;
    size_j          = '0;
    data_a          = '0;
    data_b          = '0;
    data_a_i_enable = 1'b0;
    data_a_j_enable = 1'b0;
    data_b_i_enable = 1'b0;
    data_b_j_enable = 1'b0;
    lfsr            = 16'd50;
    repeat (5) @(posedge CLK);
    RST <= 1'b0;

    // Quiet outputs before the first start
    repeat (4) begin
      @(posedge CLK);
      check_value("ready", 0, ready);
      check_value("data_out_i_enable", 0, data_out_i_enable);
      check_value("data_out_j_enable", 0, data_out_j_enable);
      check_value("data_out", 0, data_out);
      check_value("rest_out", 0, rest_out);
    end

    run_matrix(3, 4, 0);
    run_matrix(2, 3, 1);
    // Back to back, sizes relatched on each start
    run_matrix(1, 1, 0);
    run_matrix(2, 1, 0);

    if (i_dut.u_matrix_divider.u_properties.error_count == 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      stop_with_failure("Strobe protocol assertions failed during the run");
    end
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+design
design/matrix_div_pkg.sv
design/vector_div_if.sv
design/integer_divider.sv
design/vector_integer_divider.sv
design/matrix_integer_divider.sv
design/matrix_div_top.sv
test/matrix_div_properties.sv
test/matrix_div_tb.sv
